/* tb.f */
hw/fpga_regs_pkg.sv
hw/fpga_reg_block.sv
hw/log_char_fifo.sv
hw/itrng_nibble_fifo.sv
hw/bus_reset_pulse.sv
hw/fpga_wrapper_top.sv
testbench/wrapper_checker.sv
testbench/tb_fpga_wrapper.sv

/* Makefile */
TOP := tb_fpga_wrapper

all: run

build:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)
	verilator --lint-only -f tb.f --top-module fpga_wrapper_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* testbench/tb_fpga_wrapper.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_wrapper;

    import fpga_regs_pkg::*;

    localparam int LOG_FIFO_DEPTH   = 16;
    localparam int ITRNG_FIFO_DEPTH = 4;
    localparam int BUS_RESET_CYCLES = 15;

    typedef enum int {
        OP_WRITE, OP_READ, OP_READ_BASE, OP_READ_DELTA, OP_READ_LOG,
        OP_LOG_PUSH, OP_TRNG_WRITE, OP_REQ_WINDOW, OP_IDLE
    } op_e;

    typedef struct {
        op_e         op;
        logic [3:0]  addr;
        logic [31:0] data;     // Write data or expected read value
        int          cycles;
    } step_t;

    logic        core_clk;
    logic        hwif_out;
    logic        reg_wr_en;
    logic        reg_rd_en;
    logic [3:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        reg_rd_valid;
    logic        log_char_we;
    logic [7:0]  log_char;
    logic        etrng_req;
    logic [3:0]  itrng_data;
    logic        itrng_valid;
    logic        bus_reset_n;
    logic        core_rst_b;
    logic        debug_locked;

    step_t       steps[$];
    int          total_cycles = 0;
    int          cycle_limit = 0;
    int          cycle_cnt = 0;
    logic [31:0] lcg_state = 32'd36;

    fpga_wrapper_top #(
        .LOG_FIFO_DEPTH   (LOG_FIFO_DEPTH),
        .ITRNG_FIFO_DEPTH (ITRNG_FIFO_DEPTH),
        .BUS_RESET_CYCLES (BUS_RESET_CYCLES)
    ) UUT (
        .core_clk     (core_clk),
        .hwif_out     (hwif_out),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_rd_valid (reg_rd_valid),
        .log_char_we  (log_char_we),
        .log_char     (log_char),
        .etrng_req    (etrng_req),
        .itrng_data   (itrng_data),
        .itrng_valid  (itrng_valid),
        .bus_reset_n  (bus_reset_n),
        .core_rst_b   (core_rst_b),
        .debug_locked (debug_locked)
    );

    wrapper_checker #(
        .LOG_FIFO_DEPTH   (LOG_FIFO_DEPTH),
        .ITRNG_FIFO_DEPTH (ITRNG_FIFO_DEPTH),
        .BUS_RESET_CYCLES (BUS_RESET_CYCLES)
    ) CHK (
        .core_clk     (core_clk),
        .hwif_out     (hwif_out),
        .reg_wr_en    (reg_wr_en),
        .reg_rd_en    (reg_rd_en),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_rd_valid (reg_rd_valid),
        .log_char_we  (log_char_we),
        .log_char     (log_char),
        .itrng_data   (itrng_data),
        .itrng_valid  (itrng_valid),
        .bus_reset_n  (bus_reset_n),
        .core_rst_b   (core_rst_b),
        .debug_locked (debug_locked)
    );

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_step(input op_e op, input logic [3:0] addr,
                            input logic [31:0] data, input int cycles);
        step_t s;
        s.op = op;
        s.addr = addr;
        s.data = data;
        s.cycles = cycles;
        steps.push_back(s);
        total_cycles += cycles;
    endtask

    task automatic build_table();
        // Reset values and version
        add_step(OP_READ, ADDR_FPGA_VERSION, FPGA_VERSION, 1);
        add_step(OP_READ, ADDR_STATUS, 32'h5, 1);              // Both FIFOs empty
        add_step(OP_READ, ADDR_CYCLE_COUNT, 32'h0, 3);
        add_step(OP_WRITE, ADDR_CONTROL, 32'h1, 4);            // Release core reset
        add_step(OP_READ_BASE, ADDR_CYCLE_COUNT, 32'h0, 10);
        add_step(OP_READ_DELTA, ADDR_CYCLE_COUNT, 32'd10, 2);
        // Log FIFO fill past depth, then drain
        for (int i = 0; i < 20; i++) begin
            add_step(OP_LOG_PUSH, 4'h0, 32'h41 + i, 1);
            if (i == 15) begin
                add_step(OP_READ, ADDR_STATUS, 32'h6, 1);      // Full, not empty
            end
        end
        for (int i = 0; i < 18; i++) begin
            add_step(OP_READ_LOG, ADDR_LOG_FIFO_DATA, 32'h0, 1);
        end
        add_step(OP_READ, ADDR_STATUS, 32'h5, 2);
        // TRNG words with divisor 3
        add_step(OP_WRITE, ADDR_ITRNG_DIVISOR, 32'h3, 1);
        for (int i = 0; i < 3; i++) begin
            add_step(OP_TRNG_WRITE, ADDR_ITRNG_FIFO_DATA, 32'h0, 1);
        end
        add_step(OP_REQ_WINDOW, 4'h0, 32'h0, 120);
        add_step(OP_IDLE, 4'h0, 32'h0, 4);
        add_step(OP_READ, ADDR_STATUS, 32'h5, 2);
        // Flush mid-word
        add_step(OP_TRNG_WRITE, ADDR_ITRNG_FIFO_DATA, 32'h0, 1);
        add_step(OP_TRNG_WRITE, ADDR_ITRNG_FIFO_DATA, 32'h0, 1);
        add_step(OP_REQ_WINDOW, 4'h0, 32'h0, 22);
        add_step(OP_WRITE, ADDR_CONTROL, 32'h5, 3);
        add_step(OP_WRITE, ADDR_CONTROL, 32'h1, 1);
        add_step(OP_READ, ADDR_STATUS, 32'h5, 1);
        add_step(OP_REQ_WINDOW, 4'h0, 32'h0, 40);
        add_step(OP_IDLE, 4'h0, 32'h0, 2);
        // Bus reset pulses
        add_step(OP_WRITE, ADDR_CONTROL, 32'h3, 20);
        add_step(OP_WRITE, ADDR_CONTROL, 32'h3, 20);           // No retrigger
        add_step(OP_WRITE, ADDR_CONTROL, 32'h1, 2);
        add_step(OP_WRITE, ADDR_CONTROL, 32'h3, 20);
        // Debug lock level, trigger dropped
        add_step(OP_WRITE, ADDR_CONTROL, 32'h9, 2);
        add_step(OP_READ, ADDR_CONTROL, 32'h9, 1);
        add_step(OP_READ, ADDR_ITRNG_FIFO_DATA, 32'h0, 1);
        add_step(OP_READ, 4'hF, 32'h0, 3);                     // Unmapped
    endtask

    task automatic apply_step(input step_t s);
        reg_addr = s.addr;
        case (s.op)
            OP_WRITE: begin
                reg_wr_en = 1'b1;
                reg_wdata = s.data;
            end
            OP_TRNG_WRITE: begin
                lcg_state = lcg_step(lcg_state);
                reg_wr_en = 1'b1;
                reg_wdata = lcg_state;
            end
            OP_READ, OP_READ_BASE, OP_READ_DELTA, OP_READ_LOG: begin
                CHK.expect_read(int'(s.op) - int'(OP_READ), s.data);
                reg_rd_en = 1'b1;
            end
            OP_LOG_PUSH: begin
                log_char_we = 1'b1;
                log_char    = s.data[7:0];
            end
            OP_REQ_WINDOW: etrng_req = 1'b1;
            default: ;
        endcase
        @(posedge core_clk);
        #1;
        reg_wr_en   = 1'b0;   // Strobes last one cycle
        reg_rd_en   = 1'b0;
        log_char_we = 1'b0;
        for (int i = 1; i < s.cycles; i++) begin
            @(posedge core_clk);
            #1;
        end
        etrng_req = 1'b0;
    endtask

    always @(posedge core_clk) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        hwif_out    = 1'b0;
        reg_wr_en   = 1'b0;
        reg_rd_en   = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        log_char_we = 1'b0;
        log_char    = '0;
        etrng_req   = 1'b0;
        build_table();
        cycle_limit = 2 * total_cycles + 100;
        repeat (2) @(posedge core_clk);
        #1;
        hwif_out = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        repeat (3) @(posedge core_clk);
        CHK.final_checks();
        $display("Errors: %0d", CHK.error_count);
        if (CHK.error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/wrapper_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module wrapper_checker #(
    parameter int LOG_FIFO_DEPTH   = 16,
    parameter int ITRNG_FIFO_DEPTH = 4,
    parameter int BUS_RESET_CYCLES = 15
) (
    input wire        core_clk,
    input wire        hwif_out,
    input wire        reg_wr_en,
    input wire        reg_rd_en,
    input wire [3:0]  reg_addr,
    input wire [31:0] reg_wdata,
    input wire [31:0] reg_rdata,
    input wire        reg_rd_valid,
    input wire        log_char_we,
    input wire [7:0]  log_char,
    input wire [3:0]  itrng_data,
    input wire        itrng_valid,
    input wire        bus_reset_n,
    input wire        core_rst_b,
    input wire        debug_locked
);

    import fpga_regs_pkg::*;

    // Kinds of expected read
    localparam int READ_EXACT = 0;
    localparam int READ_BASE  = 1;   // Remember value, no compare
    localparam int READ_DELTA = 2;   // Compare difference to base
    localparam int READ_LOG   = 3;   // Expected value from the log model

    int          error_count = 0;
    int          exp_kind_q[$];
    logic [31:0] exp_val_q[$];
    logic [7:0]  char_q[$];
    logic [3:0]  nibble_q[$];
    logic [31:0] base_value = '0;
    logic [31:0] ctrl_shadow = '0;
    logic [31:0] divisor_shadow = '0;
    logic [31:0] expected;
    logic        rd_en_q = 1'b0;   // Read strobe seen one edge ago
    int          cycle = 0;
    int          last_valid = -1000;
    int          low_len = 0;
    int          pulses_seen = 0;
    int          pulses_expected = 0;
    int          kind;

    task automatic expect_read(input int k, input logic [31:0] value);
        exp_kind_q.push_back(k);
        exp_val_q.push_back(value);
    endtask

    task automatic final_checks();
        if (exp_kind_q.size() != 0) begin
            $display("Some register reads never returned data");
            error_count++;
        end
        if (low_len != 0) begin
            $display("Bus reset was still low at the end of the run");
            error_count++;
        end
        if (pulses_seen != pulses_expected) begin
            $display("Fail bus_reset_n pulses: expected %h, got %h",
                     pulses_expected, pulses_seen);
            error_count++;
        end
    endtask

    always @(posedge core_clk) begin
        if (hwif_out) begin
            cycle++;
            if (reg_rd_valid !== rd_en_q) begin
                $display("Fail reg_rd_valid: expected %h, got %h", rd_en_q, reg_rd_valid);
                error_count++;
            end
            rd_en_q = reg_rd_en;
            if (core_rst_b !== ctrl_shadow[CTRL_CORE_RST_B]) begin
                $display("Fail core_rst_b: expected %h, got %h",
                         ctrl_shadow[CTRL_CORE_RST_B], core_rst_b);
                error_count++;
            end
            if (debug_locked !== ctrl_shadow[CTRL_DEBUG_LOCKED]) begin
                $display("Fail debug_locked: expected %h, got %h",
                         ctrl_shadow[CTRL_DEBUG_LOCKED], debug_locked);
                error_count++;
            end
            if (reg_rd_valid) begin
                if (exp_kind_q.size() == 0) begin
                    $display("A read returned data that nobody asked for");
                    error_count++;
                end else begin
                    kind     = exp_kind_q.pop_front();
                    expected = exp_val_q.pop_front();
                    if (kind == READ_LOG) begin
                        expected = '0;
                        if (char_q.size() != 0) begin
                            expected = {23'd0, 1'b1, char_q.pop_front()};
                        end
                    end
                    if (kind == READ_BASE) begin
                        base_value = reg_rdata;
                    end else if (kind == READ_DELTA) begin
                        if (reg_rdata - base_value != expected) begin
                            $display("Fail reg_rdata delta: expected %h, got %h",
                                     expected, reg_rdata - base_value);
                            error_count++;
                        end
                    end else if (reg_rdata !== expected) begin
                        $display("Fail reg_rdata: expected %h, got %h", expected, reg_rdata);
                        error_count++;
                    end
                end
            end
            if (itrng_valid) begin
                if (nibble_q.size() == 0) begin
                    $display("itrng_valid pulsed while no entropy was expected");
                    error_count++;
                end else if (itrng_data !== nibble_q[0]) begin
                    $display("Fail itrng_data: expected %h, got %h", nibble_q[0], itrng_data);
                    error_count++;
                    void'(nibble_q.pop_front());
                end else begin
                    void'(nibble_q.pop_front());
                end
                if (cycle - last_valid < divisor_shadow + 1) begin
                    $display("Fail itrng_valid gap: expected %h, got %h",
                             divisor_shadow + 1, cycle - last_valid);
                    error_count++;
                end
                last_valid = cycle;
            end
            if (!bus_reset_n) begin
                low_len++;
            end else if (low_len != 0) begin
                pulses_seen++;
                if (low_len != BUS_RESET_CYCLES + 1) begin
                    $display("Fail bus_reset_n low cycles: expected %h, got %h",
                             BUS_RESET_CYCLES + 1, low_len);
                    error_count++;
                end
                low_len = 0;
            end
            if (log_char_we && char_q.size() < LOG_FIFO_DEPTH) begin
                char_q.push_back(log_char);   // Overflow dropped
            end
            if (reg_wr_en && reg_addr == ADDR_ITRNG_FIFO_DATA
                && !ctrl_shadow[CTRL_ITRNG_FIFO_RESET]
                && nibble_q.size() <= 8 * (ITRNG_FIFO_DEPTH - 1)) begin
                for (int i = 0; i < 8; i++) begin
                    nibble_q.push_back(reg_wdata[4*i +: 4]);   // LS nibble first
                end
            end
            if (reg_wr_en && reg_addr == ADDR_ITRNG_DIVISOR) begin
                divisor_shadow = reg_wdata;
            end
            if (reg_wr_en && reg_addr == ADDR_CONTROL) begin
                if (reg_wdata[CTRL_TRIGGER_BUS_RESET]
                    && !ctrl_shadow[CTRL_TRIGGER_BUS_RESET]) begin
                    pulses_expected++;
                end
                if (reg_wdata[CTRL_ITRNG_FIFO_RESET]) begin
                    nibble_q.delete();   // Flush includes partial word
                end
                ctrl_shadow = reg_wdata;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fpga_wrapper_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fpga_wrapper_top #(
    parameter int LOG_FIFO_DEPTH   = 16,
    parameter int ITRNG_FIFO_DEPTH = 4,
    parameter int BUS_RESET_CYCLES = 15
) (
    input  wire                            core_clk,
    input  wire                            hwif_out,
    // Register port
    input  wire                            reg_wr_en,
    input  wire                            reg_rd_en,
    input  wire fpga_regs_pkg::reg_addr_t  reg_addr,
    input  wire fpga_regs_pkg::reg_data_t  reg_wdata,
    output fpga_regs_pkg::reg_data_t       reg_rdata,
    output logic                           reg_rd_valid,
    // Log character source
    input  wire                            log_char_we,
    input  wire fpga_regs_pkg::log_char_t  log_char,
    // Core entropy port
    input  wire                            etrng_req,
    output fpga_regs_pkg::trng_nibble_t    itrng_data,
    output logic                           itrng_valid,
    // Levels to the core and bus
    output logic                           bus_reset_n,
    output logic                           core_rst_b,
    output logic                           debug_locked
);

    import fpga_regs_pkg::*;

    reg_data_t control;
    reg_data_t itrng_divisor;
    reg_data_t itrng_word;
    log_char_t log_head;
    logic      log_valid;
    logic      log_full;
    logic      log_pop;
    logic      itrng_push;
    logic      itrng_empty;
    logic      itrng_full;

    // Fuse-style levels read by the core
    assign core_rst_b   = control[CTRL_CORE_RST_B];
    assign debug_locked = control[CTRL_DEBUG_LOCKED];

    fpga_reg_block u_regs (
        .core_clk      (core_clk),
        .hwif_out      (hwif_out),
        .reg_wr_en     (reg_wr_en),
        .reg_rd_en     (reg_rd_en),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .log_head      (log_head),
        .log_valid     (log_valid),
        .log_full      (log_full),
        .itrng_empty   (itrng_empty),
        .itrng_full    (itrng_full),
        .reg_rdata     (reg_rdata),
        .reg_rd_valid  (reg_rd_valid),
        .control       (control),
        .itrng_divisor (itrng_divisor),
        .log_pop       (log_pop),
        .itrng_push    (itrng_push),
        .itrng_word    (itrng_word)
    );

    log_char_fifo #(
        .LOG_FIFO_DEPTH (LOG_FIFO_DEPTH)
    ) u_log_fifo (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .log_char_we (log_char_we),
        .log_char    (log_char),
        .log_pop     (log_pop),
        .log_head    (log_head),
        .log_valid   (log_valid),
        .log_full    (log_full)
    );

    itrng_nibble_fifo #(
        .ITRNG_FIFO_DEPTH (ITRNG_FIFO_DEPTH)
    ) u_itrng_fifo (
        .core_clk      (core_clk),
        .hwif_out      (hwif_out),
        .itrng_push    (itrng_push),
        .itrng_word    (itrng_word),
        .fifo_clear    (control[CTRL_ITRNG_FIFO_RESET]),
        .itrng_divisor (itrng_divisor),
        .etrng_req     (etrng_req),
        .itrng_data    (itrng_data),
        .itrng_valid   (itrng_valid),
        .itrng_empty   (itrng_empty),
        .itrng_full    (itrng_full)
    );

    bus_reset_pulse #(
        .BUS_RESET_CYCLES (BUS_RESET_CYCLES)
    ) u_bus_reset (
        .core_clk    (core_clk),
        .hwif_out    (hwif_out),
        .trigger     (control[CTRL_TRIGGER_BUS_RESET]),
        .bus_reset_n (bus_reset_n)
    );

endmodule

`default_nettype wire

/* hw/bus_reset_pulse.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_reset_pulse #(
    parameter int BUS_RESET_CYCLES = 15
) (
    input  wire  core_clk,
    input  wire  hwif_out,
    input  wire  trigger,
    output logic bus_reset_n
);

    localparam int CNT_W = (BUS_RESET_CYCLES > 0) ? $clog2(BUS_RESET_CYCLES + 1) : 1;

    logic             trigger_q;
    logic [CNT_W-1:0] remaining;

    // Low for the load cycle plus BUS_RESET_CYCLES more
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            trigger_q   <= 1'b0;
            remaining   <= '0;
            bus_reset_n <= 1'b1;
        end else begin
            trigger_q <= trigger;
            if (trigger && !trigger_q) begin   // Rising edge only
                remaining   <= CNT_W'(BUS_RESET_CYCLES);
                bus_reset_n <= 1'b0;
            end else if (remaining != '0) begin
                remaining   <= remaining - 1'b1;
                bus_reset_n <= 1'b0;
            end else begin
                bus_reset_n <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/itrng_nibble_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module itrng_nibble_fifo #(
    parameter int ITRNG_FIFO_DEPTH = 4
) (
    input  wire                            core_clk,
    input  wire                            hwif_out,
    input  wire                            itrng_push,
    input  wire fpga_regs_pkg::reg_data_t  itrng_word,
    input  wire                            fifo_clear,
    input  wire fpga_regs_pkg::reg_data_t  itrng_divisor,
    input  wire                            etrng_req,
    output fpga_regs_pkg::trng_nibble_t    itrng_data,
    output logic                           itrng_valid,
    output logic                           itrng_empty,
    output logic                           itrng_full
);

    import fpga_regs_pkg::*;

    localparam int PTR_W = (ITRNG_FIFO_DEPTH > 1) ? $clog2(ITRNG_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(ITRNG_FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(ITRNG_FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(ITRNG_FIFO_DEPTH);

    reg_data_t        mem [ITRNG_FIFO_DEPTH];
    reg_data_t        head_word;
    reg_data_t        throttle_cnt;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [2:0]       nib_idx;        // Next nibble of the head word
    logic             rd_req;
    logic             do_wr;
    logic             do_rd;
    logic             retire;

    assign itrng_empty = (count == '0);
    assign itrng_full  = (count == FULL_CNT);
    assign head_word   = mem[rd_ptr];

    // Request only counts in the cycle the throttle hits zero
    assign rd_req = (throttle_cnt == '0) && etrng_req;
    assign do_wr  = itrng_push && !itrng_full && !fifo_clear;
    assign do_rd  = rd_req && !itrng_empty && !fifo_clear;
    assign retire = do_rd && (nib_idx == 3'd7);   // Last nibble frees the word

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_cnt <= '0;
        end else if (throttle_cnt == '0) begin
            throttle_cnt <= itrng_divisor;
        end else begin
            throttle_cnt <= throttle_cnt - 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= itrng_word;
        end
        if (do_rd) begin
            itrng_data <= head_word[{nib_idx, 2'b00} +: 4];   // LS nibble first
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else if (fifo_clear) begin
            // Flush, partial word included
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            nib_idx     <= '0;
            itrng_valid <= 1'b0;
        end else begin
            itrng_valid <= do_rd;
            if (do_rd) begin
                nib_idx <= nib_idx + 1'b1;   // Wraps to 0 after nibble 7
            end
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/log_char_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module log_char_fifo #(
    parameter int LOG_FIFO_DEPTH = 16
) (
    input  wire                            core_clk,
    input  wire                            hwif_out,
    input  wire                            log_char_we,
    input  wire fpga_regs_pkg::log_char_t  log_char,
    input  wire                            log_pop,
    output fpga_regs_pkg::log_char_t       log_head,
    output logic                           log_valid,
    output logic                           log_full
);

    import fpga_regs_pkg::*;

    localparam int PTR_W = (LOG_FIFO_DEPTH > 1) ? $clog2(LOG_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(LOG_FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(LOG_FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(LOG_FIFO_DEPTH);

    log_char_t        mem [LOG_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign log_valid = (count != '0);
    assign log_full  = (count == FULL_CNT);
    assign log_head  = mem[rd_ptr];          // Oldest character falls through

    assign do_wr = log_char_we && !log_full;  // Overflow chars are lost
    assign do_rd = log_pop && log_valid;

    always_ff @(posedge core_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= log_char;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fpga_reg_block.sv */
`timescale 1ns/1ps
`default_nettype none

module fpga_reg_block (
    input  wire                            core_clk,
    input  wire                            hwif_out,
    input  wire                            reg_wr_en,
    input  wire                            reg_rd_en,
    input  wire fpga_regs_pkg::reg_addr_t  reg_addr,
    input  wire fpga_regs_pkg::reg_data_t  reg_wdata,
    input  wire fpga_regs_pkg::log_char_t  log_head,
    input  wire                            log_valid,
    input  wire                            log_full,
    input  wire                            itrng_empty,
    input  wire                            itrng_full,
    output fpga_regs_pkg::reg_data_t       reg_rdata,
    output logic                           reg_rd_valid,
    output fpga_regs_pkg::reg_data_t       control,
    output fpga_regs_pkg::reg_data_t       itrng_divisor,
    output logic                           log_pop,
    output logic                           itrng_push,
    output fpga_regs_pkg::reg_data_t       itrng_word
);

    import fpga_regs_pkg::*;

    reg_data_t cycle_count;
    reg_data_t status;
    reg_data_t rd_mux;
    logic      wr_control;
    logic      wr_divisor;

    assign wr_control = reg_wr_en && (reg_addr == ADDR_CONTROL);
    assign wr_divisor = reg_wr_en && (reg_addr == ADDR_ITRNG_DIVISOR);

    // Data register writes go straight into the TRNG FIFO
    assign itrng_push = reg_wr_en && (reg_addr == ADDR_ITRNG_FIFO_DATA);
    assign itrng_word = reg_wdata;

    // Every read of the log address pops, the FIFO ignores it while empty
    assign log_pop = reg_rd_en && (reg_addr == ADDR_LOG_FIFO_DATA);

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            control       <= '0;
            itrng_divisor <= '0;
        end else begin
            if (wr_control) begin
                control <= reg_wdata;
            end
            if (wr_divisor) begin
                itrng_divisor <= reg_wdata;
            end
        end
    end

    // Held at zero while the core sits in reset
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else if (!control[CTRL_CORE_RST_B]) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_comb begin
        status                   = '0;
        status[STAT_LOG_EMPTY]   = !log_valid;
        status[STAT_LOG_FULL]    = log_full;
        status[STAT_ITRNG_EMPTY] = itrng_empty;
        status[STAT_ITRNG_FULL]  = itrng_full;
    end

    always_comb begin
        case (reg_addr)
            ADDR_CONTROL:       rd_mux = control;
            ADDR_STATUS:        rd_mux = status;
            ADDR_ITRNG_DIVISOR: rd_mux = itrng_divisor;
            ADDR_CYCLE_COUNT:   rd_mux = cycle_count;
            ADDR_FPGA_VERSION:  rd_mux = FPGA_VERSION;
            ADDR_LOG_FIFO_DATA: rd_mux = log_valid ? {23'd0, 1'b1, log_head} : '0;  // Valid in bit 8
            default:            rd_mux = '0;   // Unmapped and write-only
        endcase
    end

    // Read data one cycle after the strobe
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            reg_rd_valid <= 1'b0;
        end else begin
            reg_rd_valid <= reg_rd_en;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reg_rd_en) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* hw/fpga_regs_pkg.sv */
`default_nettype none

package fpga_regs_pkg;

    typedef logic [3:0]  reg_addr_t;      // Register word address
    typedef logic [31:0] reg_data_t;      // Register data and TRNG word
    typedef logic [7:0]  log_char_t;
    typedef logic [3:0]  trng_nibble_t;   // Entropy handed to the core per valid

    // Register map, word addresses
    localparam reg_addr_t ADDR_CONTROL         = 4'd0;
    localparam reg_addr_t ADDR_STATUS          = 4'd1;   // Read only
    localparam reg_addr_t ADDR_ITRNG_DIVISOR   = 4'd2;
    localparam reg_addr_t ADDR_CYCLE_COUNT     = 4'd3;   // Read only
    localparam reg_addr_t ADDR_FPGA_VERSION    = 4'd4;   // Read only
    localparam reg_addr_t ADDR_LOG_FIFO_DATA   = 4'd5;   // Read pops a character
    localparam reg_addr_t ADDR_ITRNG_FIFO_DATA = 4'd6;   // Write only

    // Control register bits
    localparam int CTRL_CORE_RST_B        = 0;
    localparam int CTRL_TRIGGER_BUS_RESET = 1;
    localparam int CTRL_ITRNG_FIFO_RESET  = 2;
    localparam int CTRL_DEBUG_LOCKED      = 3;

    // Status register bits
    localparam int STAT_LOG_EMPTY   = 0;
    localparam int STAT_LOG_FULL    = 1;
    localparam int STAT_ITRNG_EMPTY = 2;
    localparam int STAT_ITRNG_FULL  = 3;

    // Bumped on every bitstream release
    localparam reg_data_t FPGA_VERSION = 32'h0001_0300;

endpackage

`default_nettype wire
